//--- filelist.f
+incdir+source
source/rv_exec_pkg.sv
source/rv_alu.sv
source/rv_muldiv.sv
source/rv_next_pc.sv
source/rv_execute.sv
source/rv_retire.sv
source/rv_exec_top.sv
verification/rv_exec_tb.sv

//--- source/rv_alu.sv
`timescale 1ns/100ps
`include "rv_exec_params.svh"

module rv_alu (
    input  rv_exec_pkg::alu_op_e op,
    input  logic [`RV_XLEN-1:0]  a,
    input  logic [`RV_XLEN-1:0]  b,
    output logic [`RV_XLEN-1:0]  result,
    output logic                 zero
);
    logic [$clog2(`RV_XLEN)-1:0] shamt;
    logic                        lt_signed;
    logic                        lt_unsigned;

    assign shamt       = b[$clog2(`RV_XLEN)-1:0]; // low six bits only
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            rv_exec_pkg::ADD: begin
                result = a + b;
            end
            rv_exec_pkg::SUB: begin
                result = a - b; // also feeds BEQ/BNE
            end
            rv_exec_pkg::SLL: begin
                result = a << shamt;
            end
            rv_exec_pkg::SLT: begin
                result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
            end
            rv_exec_pkg::SLTU: begin
                result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
            end
            rv_exec_pkg::XOR: begin
                result = a ^ b;
            end
            rv_exec_pkg::SRL: begin
                result = a >> shamt;
            end
            rv_exec_pkg::SRA: begin
                result = $signed(a) >>> shamt;
            end
            rv_exec_pkg::OR: begin
                result = a | b;
            end
            rv_exec_pkg::AND: begin
                result = a & b;
            end
            rv_exec_pkg::PASS_B: begin
                result = b; // lui, csr read
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- source/rv_exec_params.svh
`ifndef RV_EXEC_PARAMS_SVH
`define RV_EXEC_PARAMS_SVH

// one machine word
`define RV_XLEN 64

// raw immediate as handed over by decode
`define RV_IMM_W 32

`define RV_REG_W 5
`define RV_CSR_W 12

`endif

//--- source/rv_exec_pkg.sv
`include "rv_exec_params.svh"

package rv_exec_pkg;

    // top bit set selects the multiply/divide unit
    typedef enum logic [5:0] {
        ADD    = 6'h00,
        SUB    = 6'h01,
        SLL    = 6'h02,
        SLT    = 6'h03,
        SLTU   = 6'h04,
        XOR    = 6'h05,
        SRL    = 6'h06,
        SRA    = 6'h07,
        OR     = 6'h08,
        AND    = 6'h09,
        PASS_B = 6'h0a,
        MUL    = 6'h20,
        MULH   = 6'h21,
        MULHSU = 6'h22,
        MULHU  = 6'h23,
        DIV    = 6'h24,
        DIVU   = 6'h25,
        REM    = 6'h26,
        REMU   = 6'h27
    } alu_op_e;

    typedef enum logic {
        A_RS1 = 1'b0,
        A_PC  = 1'b1
    } a_src_e;

    typedef enum logic [1:0] {
        B_RS2  = 2'd0,
        B_FOUR = 2'd1,
        B_IMM  = 2'd2,
        B_CSR  = 2'd3
    } b_src_e;

    // nine kinds need four bits
    typedef enum logic [3:0] {
        NONE = 4'd0,
        JAL  = 4'd1,
        JALR = 4'd2,
        BEQ  = 4'd3,
        BNE  = 4'd4,
        BLT  = 4'd5,
        BGE  = 4'd6,
        BLTU = 4'd7,
        BGEU = 4'd8
    } branch_e;

    typedef struct packed {
        logic [`RV_XLEN-1:0]  pc;
        logic [`RV_XLEN-1:0]  rs1_data;
        logic [`RV_XLEN-1:0]  rs2_data;
        logic [`RV_IMM_W-1:0] imm;
        logic [`RV_XLEN-1:0]  csr_data;
        logic [`RV_CSR_W-1:0] csr_addr;
        logic [`RV_REG_W-1:0] rd;
        a_src_e               a_src;
        b_src_e               b_src;
        alu_op_e              alu_op;
        branch_e              branch;
        logic                 mem_rd;
        logic                 mem_wr;
        logic                 reg_wr;
        logic                 csr;
        logic                 ecall;
        logic                 mret;
        logic                 done;
        logic                 error;
    } ex_req_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]  result;
        logic [`RV_XLEN-1:0]  next_pc;
        logic                 jump;
        logic [`RV_REG_W-1:0] rd;
        logic [`RV_CSR_W-1:0] csr_addr;
        logic                 mem_rd;
        logic                 mem_wr;
        logic                 reg_wr;
        logic                 csr;
        logic                 ecall;
        logic                 mret;
        logic                 done;
        logic                 error;
    } ex_resp_t;

endpackage

//--- source/rv_exec_top.sv
`timescale 1ns/100ps

module rv_exec_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  block,
    input  logic                  raise_intr,
    input  logic                  in_valid,
    input  rv_exec_pkg::ex_req_t  req,
    output logic                  out_valid,
    output rv_exec_pkg::ex_resp_t resp
);
    rv_exec_pkg::ex_resp_t ex_resp;
    logic                  ex_valid;

    rv_execute execute0 (
        .clk      (clk),
        .reset    (reset),
        .block    (block),
        .in_valid (in_valid),
        .req      (req),
        .ex_valid (ex_valid),
        .ex_resp  (ex_resp)
    );

    rv_retire retire0 (
        .clk        (clk),
        .reset      (reset),
        .block      (block),
        .raise_intr (raise_intr),
        .ex_valid   (ex_valid),
        .ex_resp    (ex_resp),
        .out_valid  (out_valid),
        .resp       (resp)
    );

endmodule

//--- source/rv_execute.sv
`timescale 1ns/100ps
`include "rv_exec_params.svh"

module rv_execute (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  block,
    input  logic                  in_valid,
    input  rv_exec_pkg::ex_req_t  req,
    output logic                  ex_valid,
    output rv_exec_pkg::ex_resp_t ex_resp
);
    rv_exec_pkg::ex_req_t req_q;
    logic [`RV_XLEN-1:0]  imm_ext;
    logic [`RV_XLEN-1:0]  op_a;
    logic [`RV_XLEN-1:0]  op_b;
    logic [`RV_XLEN-1:0]  alu_result;
    logic [`RV_XLEN-1:0]  md_result;
    logic [`RV_XLEN-1:0]  next_pc;
    logic                 alu_zero;
    logic                 md_illegal;
    logic                 taken;
    logic                 is_md;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid      <= 1'b0;
            req_q.alu_op  <= rv_exec_pkg::ADD;
            req_q.branch  <= rv_exec_pkg::NONE;
            req_q.mem_rd  <= 1'b0;
            req_q.mem_wr  <= 1'b0;
            req_q.reg_wr  <= 1'b0;
            req_q.csr     <= 1'b0;
            req_q.ecall   <= 1'b0;
            req_q.mret    <= 1'b0;
            req_q.done    <= 1'b0;
            req_q.error   <= 1'b0;
        end else if (!block) begin
            ex_valid <= in_valid;
            req_q    <= req;
        end
    end

    assign imm_ext = {{(`RV_XLEN-`RV_IMM_W){req_q.imm[`RV_IMM_W-1]}}, req_q.imm};
    assign op_a    = (req_q.a_src == rv_exec_pkg::A_PC) ? req_q.pc : req_q.rs1_data;

    always_comb begin
        case (req_q.b_src)
            rv_exec_pkg::B_RS2:  op_b = req_q.rs2_data;
            rv_exec_pkg::B_FOUR: op_b = `RV_XLEN'(4); // link address
            rv_exec_pkg::B_IMM:  op_b = imm_ext;
            default:             op_b = req_q.csr_data;
        endcase
    end

    rv_alu alu0 (.op(req_q.alu_op), .a(op_a), .b(op_b), .result(alu_result), .zero(alu_zero));

    // muldiv works on the raw register values
    rv_muldiv muldiv0 (
        .op      (req_q.alu_op),
        .a       (req_q.rs1_data),
        .b       (req_q.rs2_data),
        .result  (md_result),
        .illegal (md_illegal)
    );

    rv_next_pc next_pc0 (
        .branch   (req_q.branch),
        .pc       (req_q.pc),
        .rs1_data (req_q.rs1_data),
        .imm      (imm_ext),
        .zero     (alu_zero),
        .lsb      (alu_result[0]),
        .next_pc  (next_pc),
        .taken    (taken)
    );

    assign is_md = req_q.alu_op[5];

    always_comb begin
        ex_resp.result   = is_md ? md_result : alu_result;
        ex_resp.next_pc  = next_pc;
        ex_resp.jump     = (taken || req_q.csr) && ex_valid; // csr ops flush too
        ex_resp.rd       = req_q.rd;
        ex_resp.csr_addr = req_q.csr_addr;
        ex_resp.mem_rd   = req_q.mem_rd;
        ex_resp.mem_wr   = req_q.mem_wr;
        ex_resp.reg_wr   = req_q.reg_wr;
        ex_resp.csr      = req_q.csr;
        ex_resp.ecall    = req_q.ecall;
        ex_resp.mret     = req_q.mret;
        ex_resp.done     = req_q.done;
        ex_resp.error    = req_q.error || (is_md && md_illegal);
    end

    assert property (@(posedge clk) !reset && block |=> $stable(ex_valid))
        else $error("execute valid changed under block");

endmodule

//--- source/rv_muldiv.sv
`timescale 1ns/100ps
`include "rv_exec_params.svh"

module rv_muldiv (
    input  rv_exec_pkg::alu_op_e op,
    input  logic [`RV_XLEN-1:0]  a,
    input  logic [`RV_XLEN-1:0]  b,
    output logic [`RV_XLEN-1:0]  result,
    output logic                 illegal
);
    logic [2*`RV_XLEN-1:0] prod_ss;
    logic [2*`RV_XLEN-1:0] prod_su;
    logic [2*`RV_XLEN-1:0] prod_uu;
    logic [`RV_XLEN-1:0]   div_s;
    logic [`RV_XLEN-1:0]   div_u;
    logic [`RV_XLEN-1:0]   quot_s;
    logic [`RV_XLEN-1:0]   rem_s;
    logic                  div_zero;
    logic                  overflow;

    assign prod_ss = $signed({{`RV_XLEN{a[`RV_XLEN-1]}}, a}) *
                     $signed({{`RV_XLEN{b[`RV_XLEN-1]}}, b});
    assign prod_su = $signed({{`RV_XLEN{a[`RV_XLEN-1]}}, a}) * $signed({{`RV_XLEN{1'b0}}, b});
    assign prod_uu = {{`RV_XLEN{1'b0}}, a} * {{`RV_XLEN{1'b0}}, b};

    assign div_zero = (b == '0);
    assign overflow = a[`RV_XLEN-1] && (a[`RV_XLEN-2:0] == '0) && (&b); // min / -1

    // dividing by one on overflow yields min and a zero remainder for free
    assign div_s = (div_zero || overflow) ? {{(`RV_XLEN-1){1'b0}}, 1'b1} : b;
    assign div_u = div_zero ? {{(`RV_XLEN-1){1'b0}}, 1'b1} : b;

    assign quot_s = $signed(a) / $signed(div_s);
    assign rem_s  = $signed(a) % $signed(div_s);

    always_comb begin
        illegal = 1'b0;
        case (op)
            rv_exec_pkg::MUL:    result = prod_ss[`RV_XLEN-1:0];
            rv_exec_pkg::MULH:   result = prod_ss[2*`RV_XLEN-1:`RV_XLEN];
            rv_exec_pkg::MULHSU: result = prod_su[2*`RV_XLEN-1:`RV_XLEN];
            rv_exec_pkg::MULHU:  result = prod_uu[2*`RV_XLEN-1:`RV_XLEN];
            rv_exec_pkg::DIV:    result = div_zero ? '1 : quot_s;
            rv_exec_pkg::DIVU:   result = div_zero ? '1 : a / div_u;
            rv_exec_pkg::REM:    result = div_zero ? a : rem_s;
            rv_exec_pkg::REMU:   result = div_zero ? a : a % div_u;
            default: begin
                result  = '0;
                illegal = op[5]; // unused code inside the group
            end
        endcase
    end

    always_comb begin
        if (op[5] && !illegal && !$isunknown({op, a, b}))
            assert #0 (!$isunknown(result)) else $error("muldiv gave X for op %s", op.name());
    end

endmodule

//--- source/rv_next_pc.sv
`timescale 1ns/100ps
`include "rv_exec_params.svh"

module rv_next_pc (
    input  rv_exec_pkg::branch_e branch,
    input  logic [`RV_XLEN-1:0]  pc,
    input  logic [`RV_XLEN-1:0]  rs1_data,
    input  logic [`RV_XLEN-1:0]  imm,
    input  logic                 zero,
    input  logic                 lsb,
    output logic [`RV_XLEN-1:0]  next_pc,
    output logic                 taken
);
    logic [`RV_XLEN-1:0] target;
    logic [`RV_XLEN-1:0] jalr_sum;

    assign jalr_sum = rs1_data + imm;

    always_comb begin
        target = pc + imm;
        case (branch)
            rv_exec_pkg::JAL:  taken = 1'b1;
            rv_exec_pkg::JALR: begin
                taken  = 1'b1;
                target = {jalr_sum[`RV_XLEN-1:1], 1'b0};
            end
            rv_exec_pkg::BEQ:  taken = zero;  // sub result
            rv_exec_pkg::BNE:  taken = !zero;
            rv_exec_pkg::BLT,
            rv_exec_pkg::BLTU: taken = lsb;   // slt / sltu bit
            rv_exec_pkg::BGE,
            rv_exec_pkg::BGEU: taken = !lsb;
            default:           taken = 1'b0;
        endcase
    end

    assign next_pc = taken ? target : pc + `RV_XLEN'(4);

endmodule

//--- source/rv_retire.sv
`timescale 1ns/100ps

module rv_retire (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  block,
    input  logic                  raise_intr,
    input  logic                  ex_valid,
    input  rv_exec_pkg::ex_resp_t ex_resp,
    output logic                  out_valid,
    output rv_exec_pkg::ex_resp_t resp
);
    rv_exec_pkg::ex_resp_t resp_q;
    logic                  valid_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q       <= 1'b0;
            resp_q.jump   <= 1'b0;
            resp_q.mem_rd <= 1'b0;
            resp_q.mem_wr <= 1'b0;
            resp_q.reg_wr <= 1'b0;
            resp_q.csr    <= 1'b0;
            resp_q.ecall  <= 1'b0;
            resp_q.mret   <= 1'b0;
            resp_q.done   <= 1'b0;
            resp_q.error  <= 1'b0;
        end else if (!block) begin
            valid_q <= ex_valid;
            resp_q  <= ex_resp;
        end
    end

    // interrupt kills the instruction and its redirect
    assign out_valid = valid_q && !raise_intr;

    always_comb begin
        resp      = resp_q;
        resp.jump = resp_q.jump && !raise_intr;
    end

    assert property (@(posedge clk) raise_intr |-> !out_valid)
        else $error("out_valid high during interrupt");

endmodule

//--- verification/rv_exec_tb.sv
`timescale 1ns/100ps
`include "rv_exec_params.svh"

module rv_exec_tb;
    logic                  clk;
    logic                  reset;
    logic                  block;
    logic                  raise_intr;
    logic                  in_valid;
    rv_exec_pkg::ex_req_t  req;
    logic                  out_valid;
    rv_exec_pkg::ex_resp_t resp;

    rv_exec_pkg::ex_resp_t exp_q[$];
    int                    tag_q[$];  // unblocked edge count at acceptance
    int                    adv = 0;
    logic                  mon_on = 1'b0;
    logic                  held = 1'b0;
    logic                  prev_intr = 1'b0;
    logic                  prev_valid = 1'b0;
    rv_exec_pkg::ex_resp_t prev_resp;

    rv_exec_top dut0 (
        .clk        (clk),
        .reset      (reset),
        .block      (block),
        .raise_intr (raise_intr),
        .in_valid   (in_valid),
        .req        (req),
        .out_valid  (out_valid),
        .resp       (resp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check(string name, logic [63:0] exp, logic [63:0] act);
        if (act !== exp) begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    function automatic logic [8:0] control_bits(rv_exec_pkg::ex_resp_t r);
        return {r.jump, r.mem_rd, r.mem_wr, r.reg_wr, r.csr, r.ecall, r.mret, r.done, r.error};
    endfunction

    task automatic compare_resp(string tag, rv_exec_pkg::ex_resp_t exp,
                                rv_exec_pkg::ex_resp_t act);
        check({tag, ".result"}, exp.result, act.result);
        check({tag, ".next_pc"}, exp.next_pc, act.next_pc);
        check({tag, ".rd"}, exp.rd, act.rd);
        check({tag, ".csr_addr"}, exp.csr_addr, act.csr_addr);
        check({tag, ".control"}, control_bits(exp), control_bits(act));
    endtask

    function automatic rv_exec_pkg::ex_resp_t expected_resp(rv_exec_pkg::ex_req_t r);
        rv_exec_pkg::ex_resp_t e;
        logic [`RV_XLEN-1:0]   imm;
        logic [`RV_XLEN-1:0]   a;
        logic [`RV_XLEN-1:0]   b;
        logic [`RV_XLEN-1:0]   alu;
        logic [`RV_XLEN-1:0]   md;
        logic [`RV_XLEN-1:0]   x;
        logic [`RV_XLEN-1:0]   y;
        logic [`RV_XLEN-1:0]   most_neg;
        logic [2*`RV_XLEN-1:0] sx;
        logic [2*`RV_XLEN-1:0] sy;
        logic [2*`RV_XLEN-1:0] prod;
        logic                  taken;
        logic                  bad_code;

        imm = {{(`RV_XLEN-`RV_IMM_W){r.imm[`RV_IMM_W-1]}}, r.imm};
        a = (r.a_src == rv_exec_pkg::A_PC) ? r.pc : r.rs1_data;
        case (r.b_src)
            rv_exec_pkg::B_RS2:  b = r.rs2_data;
            rv_exec_pkg::B_FOUR: b = 4;
            rv_exec_pkg::B_IMM:  b = imm;
            default:             b = r.csr_data;
        endcase
        case (r.alu_op)
            rv_exec_pkg::ADD:    alu = a + b;
            rv_exec_pkg::SUB:    alu = a - b;
            rv_exec_pkg::SLL:    alu = a << b[5:0];
            rv_exec_pkg::SLT:    alu = ($signed(a) < $signed(b)) ? 1 : 0;
            rv_exec_pkg::SLTU:   alu = (a < b) ? 1 : 0;
            rv_exec_pkg::XOR:    alu = a ^ b;
            rv_exec_pkg::SRL:    alu = a >> b[5:0];
            rv_exec_pkg::SRA:    alu = $signed(a) >>> b[5:0];
            rv_exec_pkg::OR:     alu = a | b;
            rv_exec_pkg::AND:    alu = a & b;
            rv_exec_pkg::PASS_B: alu = b;
            default:             alu = '0;
        endcase

        // multiply/divide always uses the register values
        x = r.rs1_data;
        y = r.rs2_data;
        sx = {{`RV_XLEN{x[`RV_XLEN-1]}}, x};
        sy = {{`RV_XLEN{y[`RV_XLEN-1]}}, y};
        most_neg = {1'b1, {(`RV_XLEN-1){1'b0}}};
        bad_code = 1'b0;
        case (r.alu_op)
            rv_exec_pkg::MUL: begin
                prod = sx * sy;
                md = prod[`RV_XLEN-1:0];
            end
            rv_exec_pkg::MULH: begin
                prod = sx * sy;
                md = prod[2*`RV_XLEN-1:`RV_XLEN];
            end
            rv_exec_pkg::MULHSU: begin
                prod = sx * {{`RV_XLEN{1'b0}}, y};
                md = prod[2*`RV_XLEN-1:`RV_XLEN];
            end
            rv_exec_pkg::MULHU: begin
                prod = {{`RV_XLEN{1'b0}}, x} * {{`RV_XLEN{1'b0}}, y};
                md = prod[2*`RV_XLEN-1:`RV_XLEN];
            end
            rv_exec_pkg::DIV: begin
                if (y == '0)
                    md = '1;
                else if (x == most_neg && y == '1)
                    md = most_neg;
                else
                    md = $signed(x) / $signed(y);
            end
            rv_exec_pkg::REM: begin
                if (y == '0)
                    md = x;
                else if (x == most_neg && y == '1)
                    md = '0;
                else
                    md = $signed(x) % $signed(y);
            end
            rv_exec_pkg::DIVU: md = (y == '0) ? '1 : x / y;
            rv_exec_pkg::REMU: md = (y == '0) ? x : x % y;
            default: begin
                md = '0;
                bad_code = r.alu_op[5];
            end
        endcase

        case (r.branch)
            rv_exec_pkg::JAL, rv_exec_pkg::JALR: taken = 1'b1;
            rv_exec_pkg::BEQ:                    taken = (alu == '0);
            rv_exec_pkg::BNE:                    taken = (alu != '0);
            rv_exec_pkg::BLT, rv_exec_pkg::BLTU: taken = alu[0];
            rv_exec_pkg::BGE, rv_exec_pkg::BGEU: taken = !alu[0];
            default:                             taken = 1'b0;
        endcase

        e.result = r.alu_op[5] ? md : alu;
        if (!taken)
            e.next_pc = r.pc + 4;
        else if (r.branch == rv_exec_pkg::JALR)
            e.next_pc = (r.rs1_data + imm) & ~64'd1;
        else
            e.next_pc = r.pc + imm;
        e.jump     = taken || r.csr;
        e.rd       = r.rd;
        e.csr_addr = r.csr_addr;
        e.mem_rd   = r.mem_rd;
        e.mem_wr   = r.mem_wr;
        e.reg_wr   = r.reg_wr;
        e.csr      = r.csr;
        e.ecall    = r.ecall;
        e.mret     = r.mret;
        e.done     = r.done;
        e.error    = r.error || bad_code;
        return e;
    endfunction

    // kind 0 alu, 1 multiply/divide, 2 control flow
    function automatic rv_exec_pkg::ex_req_t random_req(int kind);
        rv_exec_pkg::ex_req_t r;
        r.pc       = {$urandom, $urandom};
        r.rs1_data = {$urandom, $urandom};
        r.rs2_data = {$urandom, $urandom};
        r.imm      = $urandom;
        r.csr_data = {$urandom, $urandom};
        r.csr_addr = `RV_CSR_W'($urandom);
        r.rd       = `RV_REG_W'($urandom);
        r.a_src    = rv_exec_pkg::a_src_e'(1'($urandom_range(0, 1)));
        r.b_src    = rv_exec_pkg::b_src_e'(2'($urandom_range(0, 3)));
        r.alu_op   = rv_exec_pkg::alu_op_e'(6'($urandom_range(0, 10)));
        r.branch   = rv_exec_pkg::NONE;
        r.csr      = 1'b0;
        {r.mem_rd, r.mem_wr, r.reg_wr, r.ecall, r.mret, r.done, r.error} = 7'($urandom);
        if (kind == 1) begin
            r.alu_op = rv_exec_pkg::alu_op_e'(6'(6'h20 + $urandom_range(0, 7)));
            if ($urandom_range(0, 7) == 0)
                r.alu_op = rv_exec_pkg::alu_op_e'(6'(6'h28 + $urandom_range(0, 23)));
            if ($urandom_range(0, 3) == 0)
                r.rs2_data = $urandom_range(0, 2); // small divisors, zero too
        end else if (kind == 2) begin
            r.branch = rv_exec_pkg::branch_e'(4'($urandom_range(0, 8)));
            r.csr    = ($urandom_range(0, 3) == 0);
            r.a_src  = rv_exec_pkg::A_RS1;
            r.b_src  = rv_exec_pkg::B_RS2;
            if ($urandom_range(0, 3) == 0)
                r.rs2_data = r.rs1_data;
            case (r.branch)
                rv_exec_pkg::BEQ, rv_exec_pkg::BNE:   r.alu_op = rv_exec_pkg::SUB;
                rv_exec_pkg::BLT, rv_exec_pkg::BGE:   r.alu_op = rv_exec_pkg::SLT;
                rv_exec_pkg::BLTU, rv_exec_pkg::BGEU: r.alu_op = rv_exec_pkg::SLTU;
                rv_exec_pkg::JAL, rv_exec_pkg::JALR: begin
                    r.a_src  = rv_exec_pkg::A_PC; // link value
                    r.b_src  = rv_exec_pkg::B_FOUR;
                    r.alu_op = rv_exec_pkg::ADD;
                end
                default: begin
                    r.b_src  = rv_exec_pkg::B_CSR;
                    r.alu_op = rv_exec_pkg::PASS_B;
                end
            endcase
        end
        return r;
    endfunction

    task automatic drive(rv_exec_pkg::ex_req_t r, logic v, logic blk, logic intr);
        @(posedge clk);
        req        <= r;
        in_valid   <= v;
        block      <= blk;
        raise_intr <= intr;
    endtask

    task automatic directed_divides();
        rv_exec_pkg::ex_req_t r;
        for (int i = 0; i < 4; i++) begin
            r = random_req(1);
            r.alu_op   = rv_exec_pkg::alu_op_e'(6'(6'h24 + i));
            r.rs2_data = '0;
            drive(r, 1'b1, 1'b0, 1'b0);
        end
        // most negative over minus one, DIV then REM
        for (int i = 0; i < 2; i++) begin
            r = random_req(1);
            r.alu_op   = rv_exec_pkg::alu_op_e'(6'(6'h24 + 2 * i));
            r.rs1_data = {1'b1, {(`RV_XLEN-1){1'b0}}};
            r.rs2_data = '1;
            drive(r, 1'b1, 1'b0, 1'b0);
        end
        r = random_req(1);
        r.alu_op = rv_exec_pkg::alu_op_e'(6'h3f);
        drive(r, 1'b1, 1'b0, 1'b0);
    endtask

    // outputs are read at the edge, before the registers move
    always @(posedge clk) begin : monitor
        logic due;
        due = 1'b0;
        if (mon_on) begin
            if (tag_q.size() != 0)
                due = (tag_q[0] + 1 == adv);
            check("out_valid", due && !raise_intr, out_valid);
            if (due && !raise_intr)
                compare_resp("resp", exp_q[0], resp);
            if (held && raise_intr == prev_intr) begin
                check("held out_valid", prev_valid, out_valid);
                compare_resp("held resp", prev_resp, resp);
            end
            if (!block) begin
                if (due) begin
                    void'(exp_q.pop_front()); // consumed, or killed by raise_intr
                    void'(tag_q.pop_front());
                end
                adv++;
                if (in_valid) begin
                    exp_q.push_back(expected_resp(req));
                    tag_q.push_back(adv);
                end
            end
            held       = block;
            prev_intr  = raise_intr;
            prev_valid = out_valid;
            prev_resp  = resp;
        end
    end

    initial begin : stimulus
        int waited;
        void'($urandom(32'hf403dc82));
        reset      = 1'b1;
        block      = 1'b0;
        raise_intr = 1'b0;
        in_valid   = 1'b0;
        req        = '0;
        repeat (5) @(posedge clk);
        reset  <= 1'b0;
        mon_on <= 1'b1;
        @(posedge clk);
        check("out_valid after reset", 1'b0, out_valid);
        check("resp.control after reset", 9'h0, control_bits(resp));

        for (int i = 0; i < 300; i++)
            drive(random_req(0), $urandom_range(0, 4) != 0, 1'b0, 1'b0);
        for (int i = 0; i < 200; i++)
            drive(random_req(1), 1'b1, 1'b0, 1'b0);
        directed_divides();
        for (int i = 0; i < 200; i++)
            drive(random_req(2), 1'b1, 1'b0, 1'b0);
        // back-pressure and interrupt kills
        for (int i = 0; i < 600; i++)
            drive(random_req($urandom_range(0, 2)), $urandom_range(0, 3) != 0,
                  $urandom_range(0, 3) == 0, $urandom_range(0, 7) == 0);

        drive(random_req(0), 1'b0, 1'b0, 1'b0);
        waited = 0;
        while (tag_q.size() != 0 && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        if (tag_q.size() != 0) begin
            $display("timeout, %0d instructions never left the pipeline", tag_q.size());
            abort_run();
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule
